// ==== sources.f ====
common/motor_pkg.sv
common/timing_pkg.sv
src/pwm_trigger_divider.sv
pwm/duty_shadow_register.sv
pwm/three_phase_pwm.sv
src/motor_drive_top.sv
tests/motor_drive_checker.sv
tests/motor_drive_monitor.sv
tests/motor_drive_tb.sv

// ==== Bender.yml ====
package:
  name: motor_drive

sources:
  - common/motor_pkg.sv
  - common/timing_pkg.sv
  - src/pwm_trigger_divider.sv
  - pwm/duty_shadow_register.sv
  - pwm/three_phase_pwm.sv
  - src/motor_drive_top.sv
  - target: test
    files:
      - tests/motor_drive_checker.sv
      - tests/motor_drive_monitor.sv
      - tests/motor_drive_tb.sv

// ==== tests/motor_drive_tb.sv ====
`timescale 1ns/1ns

module motor_drive_tb;

    localparam int NUM_MOTORS     = 2;
    localparam int PWM_PERIOD     = 40;
    localparam int MAX_ON_CYCLES  = 36;
    localparam int TRIGGER_DIVIDE = 5;
    localparam int SEED           = 30919;
    localparam int HALF_PERIOD    = 20;
    localparam int RESET_CYCLES   = 5;
    localparam int MIN_GAP        = 9;
    localparam int MAX_GAP        = 12;
    localparam int WAIT_LIMIT     = 200;
    localparam int NUM_TESTS      = 6;

    logic                   CLK25MHz;
    logic                   reset_150mhz;
    logic                   sample_strobe;
    logic                   fault;
    logic [NUM_MOTORS-1:0]  cmd_valid;
    motor_pkg::phase_cmd_t  cmd_data       [NUM_MOTORS];
    motor_pkg::phase_bits_t driver_pwm     [NUM_MOTORS];
    motor_pkg::phase_bits_t driver_reset_n [NUM_MOTORS];

    int   test_id;
    logic test_done;
    logic window_open;
    int   tests_passed;
    int   tests_failed;
    int   stall_errors;

    motor_drive_top #(
        .NUM_MOTORS     (NUM_MOTORS),
        .PWM_PERIOD     (PWM_PERIOD),
        .MAX_ON_CYCLES  (MAX_ON_CYCLES),
        .TRIGGER_DIVIDE (TRIGGER_DIVIDE)
    ) motor_drive_top_inst (
        .CLK25MHz       (CLK25MHz),
        .reset_150mhz   (reset_150mhz),
        .sample_strobe  (sample_strobe),
        .fault          (fault),
        .cmd_valid      (cmd_valid),
        .cmd_data       (cmd_data),
        .driver_pwm     (driver_pwm),
        .driver_reset_n (driver_reset_n)
    );

    motor_drive_monitor #(
        .NUM_MOTORS     (NUM_MOTORS),
        .PWM_PERIOD     (PWM_PERIOD),
        .MAX_ON_CYCLES  (MAX_ON_CYCLES),
        .TRIGGER_DIVIDE (TRIGGER_DIVIDE)
    ) motor_drive_monitor_inst (
        .CLK25MHz       (CLK25MHz),
        .reset_150mhz   (reset_150mhz),
        .sample_strobe  (sample_strobe),
        .fault          (fault),
        .cmd_valid      (cmd_valid),
        .cmd_data       (cmd_data),
        .driver_pwm     (driver_pwm),
        .driver_reset_n (driver_reset_n),
        .test_id        (test_id),
        .test_done      (test_done),
        .window_open    (window_open),
        .tests_passed   (tests_passed),
        .tests_failed   (tests_failed)
    );

    initial begin
        CLK25MHz = 1'b0;
        forever #HALF_PERIOD CLK25MHz = ~CLK25MHz;
    end

    // mix of zero, normal, clamped and far out of range duties
    function automatic motor_pkg::duty_t random_duty(input int category);
        case (category)
            0: return '0;
            1: return motor_pkg::duty_t'($urandom_range(MAX_ON_CYCLES - 1, 1));
            2: return motor_pkg::duty_t'($urandom_range(PWM_PERIOD, MAX_ON_CYCLES));
            default: return motor_pkg::duty_t'($urandom_range(4095, PWM_PERIOD + 1));
        endcase
    endfunction

    function automatic motor_pkg::phase_cmd_t random_cmd(input int motor, input bit split);
        motor_pkg::phase_cmd_t cmd;
        int category;
        for (int p = 0; p < motor_pkg::NUM_PHASES; p++) begin
            if (!split) begin
                category = $urandom_range(3, 0);
            end else if (motor == 0) begin
                category = 1;
            end else begin
                category = $urandom_range(3, 2);
            end
            cmd[p] = random_duty(category);
        end
        return cmd;
    endfunction

    // cmd_mode 1 sends one command per trigger interval, 2 sends bursts
    task automatic run_strobes(input int num_strobes, input int cmd_mode, input bit split,
                               input int fault_start, input int fault_len);
        int gap;
        int cycle;
        cycle = 0;
        for (int i = 0; i < num_strobes; i++) begin
            gap = $urandom_range(MAX_GAP, MIN_GAP);
            for (int c = 0; c < gap; c++) begin
                @(negedge CLK25MHz);
                sample_strobe = (c == gap - 1);
                fault = (cycle >= fault_start) && (cycle < fault_start + fault_len);
                cmd_valid = '0;
                for (int m = 0; m < NUM_MOTORS; m++) begin
                    if ((cmd_mode == 1 && i % TRIGGER_DIVIDE == 1 && c == 0) ||
                        (cmd_mode == 2 && $urandom_range(3, 0) == 0)) begin
                        cmd_valid[m] = 1'b1;
                        cmd_data[m] = random_cmd(m, split);
                    end
                end
                cycle++;
            end
        end
    endtask

    task automatic end_test();
        test_done = 1'b1;
        @(negedge CLK25MHz);
        test_done = 1'b0;
        sample_strobe = 1'b0;
        cmd_valid = '0;
        fault = 1'b0;
        test_id++;
    endtask

    task automatic wait_window(input logic level);
        int waited;
        waited = 0;
        while (window_open !== level && waited < WAIT_LIMIT) begin
            @(negedge CLK25MHz);
            sample_strobe = 1'b0;
            cmd_valid = '0;
            waited++;
        end
        if (window_open !== level) begin
            $display("timeout after %0d cycles waiting for a PWM period to %s",
                     WAIT_LIMIT, level ? "start" : "finish");
            stall_errors++;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset_150mhz <= 1'b1;
        sample_strobe = 1'b0;
        fault = 1'b0;
        cmd_valid = '0;
        for (int m = 0; m < NUM_MOTORS; m++) begin
            cmd_data[m] = '0;
        end
        test_id = 1;
        test_done = 1'b0;
        stall_errors = 0;
        repeat (RESET_CYCLES) @(posedge CLK25MHz);
        @(negedge CLK25MHz);
        reset_150mhz <= 1'b0;

        // each test ends on a trigger strobe, after the last period closed
        run_strobes(TRIGGER_DIVIDE, 0, 1'b0, 0, 0);
        end_test();
        run_strobes(4 * TRIGGER_DIVIDE, 1, 1'b0, 0, 0);
        end_test();
        run_strobes(8 * TRIGGER_DIVIDE, 1, 1'b0, 0, 0);
        end_test();
        run_strobes(4 * TRIGGER_DIVIDE, 2, 1'b0, 0, 0);
        end_test();
        // fault in mid period, then a fault that swallows a whole trigger
        run_strobes(TRIGGER_DIVIDE, 1, 1'b0, 15, 8);
        run_strobes(2 * TRIGGER_DIVIDE, 1, 1'b0, 30, 40);
        end_test();
        run_strobes(5 * TRIGGER_DIVIDE, 1, 1'b1, 0, 0);
        wait_window(1'b1);
        wait_window(1'b0);
        end_test();

        @(negedge CLK25MHz);
        $display("tests passed: %0d, tests failed: %0d, timeouts: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, stall_errors,
                 motor_drive_top_inst.motor_drive_checker_inst.assert_failures);
        if (tests_failed == 0 && tests_passed == NUM_TESTS && stall_errors == 0 &&
            motor_drive_top_inst.motor_drive_checker_inst.assert_failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tests/motor_drive_monitor.sv ====
`timescale 1ns/1ns

module motor_drive_monitor #(
    parameter int NUM_MOTORS     = 2,
    parameter int PWM_PERIOD     = 40,
    parameter int MAX_ON_CYCLES  = 36,
    parameter int TRIGGER_DIVIDE = 5
) (
    input  logic                   CLK25MHz,
    input  logic                   reset_150mhz,
    input  logic                   sample_strobe,
    input  logic                   fault,
    input  logic [NUM_MOTORS-1:0]  cmd_valid,
    input  motor_pkg::phase_cmd_t  cmd_data       [NUM_MOTORS],
    input  motor_pkg::phase_bits_t driver_pwm     [NUM_MOTORS],
    input  motor_pkg::phase_bits_t driver_reset_n [NUM_MOTORS],
    input  int                     test_id,
    input  logic                   test_done,
    output logic                   window_open,
    output int                     tests_passed,
    output int                     tests_failed
);

    // edges after the trigger edge that can still show a high run
    localparam int WINDOW_EDGES = PWM_PERIOD + 2;

    int strobe_count = 0;
    logic trigger_q = 1'b0;
    logic reset_n_q = 1'b0;
    motor_pkg::phase_cmd_t pending [NUM_MOTORS];
    motor_pkg::phase_cmd_t active  [NUM_MOTORS];
    motor_pkg::phase_bits_t prev_pwm [NUM_MOTORS];
    int high_count [NUM_MOTORS][motor_pkg::NUM_PHASES];
    int window_left = 0;
    int window_runs = 0;
    int runs_seen = 0;
    int runs_expected = 0;
    int periods_checked = 0;
    int test_errors = 0;

    initial begin
        tests_passed = 0;
        tests_failed = 0;
    end

    assign window_open = (window_left > 0);

    function automatic string test_name(input int id);
        case (id)
            1: return "reset_idle";
            2: return "trigger_division";
            3: return "duty_clamp";
            4: return "shadowing";
            5: return "fault";
            6: return "independent_motors";
            default: return "unknown";
        endcase
    endfunction

    // commanded duty, never more than the on-time limit
    function automatic int expected_on(input motor_pkg::duty_t duty);
        if (int'(duty) > MAX_ON_CYCLES) begin
            return MAX_ON_CYCLES;
        end
        return int'(duty);
    endfunction

    task automatic close_window();
        int exp_on;
        for (int m = 0; m < NUM_MOTORS; m++) begin
            for (int p = 0; p < motor_pkg::NUM_PHASES; p++) begin
                exp_on = expected_on(active[m][p]);
                if (high_count[m][p] != exp_on) begin
                    $display("[FAIL] %s motor %0d phase %0d: expected %0d, actual %0d",
                             test_name(test_id), m, p, exp_on, high_count[m][p]);
                    test_errors++;
                end
                if (exp_on > 0) begin
                    runs_expected++;
                end
            end
        end
        runs_seen += window_runs;
        periods_checked++;
        window_left = 0;
    endtask

    task automatic observe_outputs();
        motor_pkg::phase_bits_t exp_reset_n;
        exp_reset_n = reset_n_q ? '1 : '0;
        for (int m = 0; m < NUM_MOTORS; m++) begin
            if (driver_reset_n[m] !== exp_reset_n) begin
                $display("[FAIL] %s motor %0d driver_reset_n: expected %b, actual %b",
                         test_name(test_id), m, exp_reset_n, driver_reset_n[m]);
                test_errors++;
            end
            if (window_left > 0) begin
                for (int p = 0; p < motor_pkg::NUM_PHASES; p++) begin
                    if (driver_pwm[m][p] === 1'b1) begin
                        high_count[m][p]++;
                        if (!prev_pwm[m][p]) begin
                            window_runs++;
                        end
                    end
                end
                prev_pwm[m] = driver_pwm[m];
            end else if (driver_pwm[m] !== '0) begin
                $display("[FAIL] %s motor %0d pwm outside a period: expected 000, actual %b",
                         test_name(test_id), m, driver_pwm[m]);
                test_errors++;
            end
        end
        if (window_left > 0) begin
            window_left--;
            if (window_left == 0) begin
                close_window();
            end
        end
    endtask

    task automatic report_test();
        if (runs_seen != runs_expected) begin
            $display("[FAIL] %s high runs: expected %0d, actual %0d",
                     test_name(test_id), runs_expected, runs_seen);
            test_errors++;
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s ok, %0d periods checked",
                     test_id, test_name(test_id), periods_checked);
        end else begin
            tests_failed++;
            $display("test %0d %s FAILED with %0d errors",
                     test_id, test_name(test_id), test_errors);
        end
        test_errors = 0;
        runs_seen = 0;
        runs_expected = 0;
        periods_checked = 0;
    endtask

    always @(posedge CLK25MHz) begin
        if (reset_150mhz) begin
            for (int m = 0; m < NUM_MOTORS; m++) begin
                if (driver_pwm[m] !== '0 || driver_reset_n[m] !== '0) begin
                    $display("[FAIL] %s motor %0d outputs not low during reset",
                             test_name(test_id), m);
                    test_errors++;
                end
                pending[m] = '0;
                active[m] = '0;
            end
            strobe_count = 0;
            trigger_q = 1'b0;
            reset_n_q = 1'b0;
            window_left = 0;
        end else begin
            observe_outputs();
            reset_n_q = !fault;
            if (trigger_q) begin
                if (window_left > 0) begin
                    close_window();
                end
                for (int m = 0; m < NUM_MOTORS; m++) begin
                    active[m] = pending[m];
                end
            end
            // fault drops the running period without a compare
            if (fault) begin
                window_left = 0;
            end else if (trigger_q) begin
                window_left = WINDOW_EDGES;
                window_runs = 0;
                for (int m = 0; m < NUM_MOTORS; m++) begin
                    prev_pwm[m] = '0;
                    for (int p = 0; p < motor_pkg::NUM_PHASES; p++) begin
                        high_count[m][p] = 0;
                    end
                end
            end
            for (int m = 0; m < NUM_MOTORS; m++) begin
                if (cmd_valid[m]) begin
                    pending[m] = cmd_data[m];
                end
            end
            trigger_q = 1'b0;
            if (sample_strobe) begin
                if (strobe_count == TRIGGER_DIVIDE - 1) begin
                    strobe_count = 0;
                    trigger_q = 1'b1;
                end else begin
                    strobe_count++;
                end
            end
        end
        if (test_done) begin
            report_test();
        end
    end

endmodule

// ==== tests/motor_drive_checker.sv ====
`timescale 1ns/1ns

module motor_drive_checker #(
    parameter int NUM_MOTORS    = 2,
    parameter int MAX_ON_CYCLES = 36
) (
    input logic                   CLK25MHz,
    input logic                   reset_150mhz,
    input motor_pkg::phase_bits_t driver_pwm     [NUM_MOTORS],
    input motor_pkg::phase_bits_t driver_reset_n [NUM_MOTORS]
);

    // failed assertions so far
    int assert_failures = 0;

    genvar m, p;
    generate
        for (m = 0; m < NUM_MOTORS; m++) begin : g_motor
            pwm_low_in_reset: assert property (@(posedge CLK25MHz)
                reset_150mhz |-> (driver_pwm[m] == '0))
                else begin
                    $error("motor %0d drives a phase during reset", m);
                    assert_failures++;
                end

            for (p = 0; p < motor_pkg::NUM_PHASES; p++) begin : g_phase
                // length of the current high run over previous samples
                int run_len;

                always @(posedge CLK25MHz or posedge reset_150mhz) begin
                    if (reset_150mhz) begin
                        run_len <= 0;
                    end else if (driver_pwm[m][p]) begin
                        run_len <= run_len + 1;
                    end else begin
                        run_len <= 0;
                    end
                end

                pwm_needs_driver: assert property (@(posedge CLK25MHz)
                    disable iff (reset_150mhz)
                    driver_pwm[m][p] |-> driver_reset_n[m][p])
                    else begin
                        $error("motor %0d phase %0d high while its gate driver is held", m, p);
                        assert_failures++;
                    end

                run_within_limit: assert property (@(posedge CLK25MHz)
                    disable iff (reset_150mhz)
                    driver_pwm[m][p] |-> (run_len < MAX_ON_CYCLES))
                    else begin
                        $error("motor %0d phase %0d high for more than %0d cycles",
                               m, p, MAX_ON_CYCLES);
                        assert_failures++;
                    end
            end
        end
    endgenerate

endmodule

bind motor_drive_top motor_drive_checker #(
    .NUM_MOTORS    (NUM_MOTORS),
    .MAX_ON_CYCLES (MAX_ON_CYCLES)
) motor_drive_checker_inst (
    .CLK25MHz       (CLK25MHz),
    .reset_150mhz   (reset_150mhz),
    .driver_pwm     (driver_pwm),
    .driver_reset_n (driver_reset_n)
);

// ==== src/motor_drive_top.sv ====
`timescale 1ns/1ns

module motor_drive_top #(
    parameter int NUM_MOTORS     = timing_pkg::DEFAULT_NUM_MOTORS,
    parameter int PWM_PERIOD     = timing_pkg::DEFAULT_PWM_PERIOD,
    parameter int MAX_ON_CYCLES  = timing_pkg::DEFAULT_MAX_ON_CYCLES,
    parameter int TRIGGER_DIVIDE = timing_pkg::DEFAULT_TRIGGER_DIVIDE
) (
    input  logic                   CLK25MHz,
    input  logic                   reset_150mhz,
    input  logic                   sample_strobe,
    input  logic                   fault,
    input  logic [NUM_MOTORS-1:0]  cmd_valid,
    input  motor_pkg::phase_cmd_t  cmd_data       [NUM_MOTORS],
    output motor_pkg::phase_bits_t driver_pwm     [NUM_MOTORS],
    output motor_pkg::phase_bits_t driver_reset_n [NUM_MOTORS]
);

    // shared by every motor so all periods start together
    logic pwm_trigger;

    pwm_trigger_divider #(
        .TRIGGER_DIVIDE (TRIGGER_DIVIDE)
    ) pwm_trigger_divider_inst (
        .CLK25MHz      (CLK25MHz),
        .reset_150mhz  (reset_150mhz),
        .sample_strobe (sample_strobe),
        .pwm_trigger   (pwm_trigger)
    );

    // one shadow register and one pwm stage per wheel motor
    genvar m;
    generate
        for (m = 0; m < NUM_MOTORS; m++) begin : g_motor
            motor_pkg::phase_cmd_t active_cmd;

            duty_shadow_register duty_shadow_register_inst (
                .CLK25MHz     (CLK25MHz),
                .reset_150mhz (reset_150mhz),
                .cmd_valid    (cmd_valid[m]),
                .cmd_data     (cmd_data[m]),
                .pwm_trigger  (pwm_trigger),
                .active_cmd   (active_cmd)
            );

            three_phase_pwm #(
                .PWM_PERIOD    (PWM_PERIOD),
                .MAX_ON_CYCLES (MAX_ON_CYCLES)
            ) three_phase_pwm_inst (
                .CLK25MHz       (CLK25MHz),
                .reset_150mhz   (reset_150mhz),
                .pwm_trigger    (pwm_trigger),
                .fault          (fault),
                .active_cmd     (active_cmd),
                .driver_pwm     (driver_pwm[m]),
                .driver_reset_n (driver_reset_n[m])
            );
        end
    endgenerate

endmodule

// ==== pwm/three_phase_pwm.sv ====
`timescale 1ns/1ns

module three_phase_pwm #(
    parameter int PWM_PERIOD    = timing_pkg::DEFAULT_PWM_PERIOD,
    parameter int MAX_ON_CYCLES = timing_pkg::DEFAULT_MAX_ON_CYCLES
) (
    input  logic                   CLK25MHz,
    input  logic                   reset_150mhz,
    input  logic                   pwm_trigger,
    input  logic                   fault,
    input  motor_pkg::phase_cmd_t  active_cmd,
    output motor_pkg::phase_bits_t driver_pwm,
    output motor_pkg::phase_bits_t driver_reset_n
);

    localparam int PERIOD_BITS = (PWM_PERIOD > 1) ? $clog2(PWM_PERIOD) : 1;

    // wide enough for both the period position and a duty value
    localparam int CNT_WIDTH =
        (PERIOD_BITS > motor_pkg::DUTY_WIDTH) ? PERIOD_BITS : motor_pkg::DUTY_WIDTH;

    localparam logic [CNT_WIDTH-1:0] LAST_CYCLE = CNT_WIDTH'(PWM_PERIOD - 1);
    localparam motor_pkg::duty_t ON_LIMIT = motor_pkg::DUTY_WIDTH'(MAX_ON_CYCLES);

    logic                 running;
    logic [CNT_WIDTH-1:0] period_count;
    logic [CNT_WIDTH-1:0] on_cycles [motor_pkg::NUM_PHASES];
    motor_pkg::phase_bits_t phase_on;

    // clamp each duty so the high side is never on for the whole period
    always_comb begin
        for (int p = 0; p < motor_pkg::NUM_PHASES; p++) begin
            if (active_cmd[p] > ON_LIMIT) begin
                on_cycles[p] = CNT_WIDTH'(ON_LIMIT);
            end else begin
                on_cycles[p] = CNT_WIDTH'(active_cmd[p]);
            end
        end
    end

    // phase is on while the period position is below its on-time
    always_comb begin
        for (int p = 0; p < motor_pkg::NUM_PHASES; p++) begin
            phase_on[p] = running && (period_count < on_cycles[p]);
        end
    end

    // period counter
    // trigger restarts it, even in the middle of a period
    // fault drops the period and waits for a fresh trigger
    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            running      <= 1'b0;
            period_count <= '0;
        end else if (fault) begin
            running      <= 1'b0;
            period_count <= '0;
        end else if (pwm_trigger) begin
            running      <= 1'b1;
            period_count <= '0;
        end else if (running) begin
            if (period_count >= LAST_CYCLE) begin
                running      <= 1'b0;
                period_count <= '0;
            end else begin
                period_count <= period_count + 1'b1;
            end
        end
    end

    // registered outputs are held low around a trigger and between periods
    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            driver_pwm <= '0;
        end else if (fault || pwm_trigger) begin
            driver_pwm <= '0;
        end else begin
            driver_pwm <= phase_on;
        end
    end

    // gate-driver resets follow the fault level one edge later
    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            driver_reset_n <= '0;
        end else if (fault) begin
            driver_reset_n <= '0;
        end else begin
            driver_reset_n <= '1;
        end
    end

endmodule

// ==== pwm/duty_shadow_register.sv ====
`timescale 1ns/1ns

module duty_shadow_register (
    input  logic                   CLK25MHz,
    input  logic                   reset_150mhz,
    input  logic                   cmd_valid,
    input  motor_pkg::phase_cmd_t  cmd_data,
    input  logic                   pwm_trigger,
    output motor_pkg::phase_cmd_t  active_cmd
);

    // latest command, waiting for the next trigger
    motor_pkg::phase_cmd_t pending_cmd;

    // no handshake here, a later strobe simply replaces the pending value
    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            pending_cmd <= '0;
        end else if (cmd_valid) begin
            pending_cmd <= cmd_data;
        end
    end

    // active copy only moves at a trigger so a running period keeps its duties
    // a strobe in the trigger cycle itself waits for the following trigger
    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            active_cmd <= '0;
        end else if (pwm_trigger) begin
            active_cmd <= pending_cmd;
        end
    end

endmodule

// ==== src/pwm_trigger_divider.sv ====
`timescale 1ns/1ns

module pwm_trigger_divider #(
    parameter int TRIGGER_DIVIDE = timing_pkg::DEFAULT_TRIGGER_DIVIDE
) (
    input  logic CLK25MHz,
    input  logic reset_150mhz,
    input  logic sample_strobe,
    output logic pwm_trigger
);

    // a divide of 1 still needs a one-bit counter
    localparam int CNT_WIDTH = (TRIGGER_DIVIDE > 1) ? $clog2(TRIGGER_DIVIDE) : 1;
    localparam logic [CNT_WIDTH-1:0] LAST_STROBE = CNT_WIDTH'(TRIGGER_DIVIDE - 1);

    logic [CNT_WIDTH-1:0] strobe_count;

    // one trigger per TRIGGER_DIVIDE strobes, so the pwm period
    // follows the filtered current sample rate
    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            strobe_count <= '0;
            pwm_trigger  <= 1'b0;
        end else begin
            pwm_trigger <= 1'b0;
            if (sample_strobe) begin
                if (strobe_count >= LAST_STROBE) begin
                    strobe_count <= '0;
                    pwm_trigger  <= 1'b1;
                end else begin
                    strobe_count <= strobe_count + 1'b1;
                end
            end
        end
    end

endmodule

// ==== common/timing_pkg.sv ====
package timing_pkg;

    // pwm period in CLK25MHz cycles
    localparam int DEFAULT_PWM_PERIOD = 3000;

    // longest allowed on-time per phase
    // keeps some off-time in every period for the bootstrap supply
    localparam int DEFAULT_MAX_ON_CYCLES = 2985;

    // adc sample strobes per pwm trigger
    localparam int DEFAULT_TRIGGER_DIVIDE = 30;

    // wheel motors on the board
    localparam int DEFAULT_NUM_MOTORS = 4;

endpackage

// ==== common/motor_pkg.sv ====
package motor_pkg;

    // phases per wheel motor
    localparam int NUM_PHASES = 3;

    // duty resolution in clock cycles
    localparam int DUTY_WIDTH = 12;

    // on-time of one phase, counted in CLK25MHz cycles
    typedef logic [DUTY_WIDTH-1:0] duty_t;

    // three-phase duty command
    // index 0 is U, 1 is V, 2 is W
    typedef duty_t [NUM_PHASES-1:0] phase_cmd_t;

    // one bit per phase, same order as phase_cmd_t
    // used for the pwm lines and the gate-driver resets
    typedef logic [NUM_PHASES-1:0] phase_bits_t;

endpackage
